// File: sgdma_buf_pkg.sv
package sgdma_buf_pkg;

    ////////////////////////////////////////
    // word and address widths
    ////////////////////////////////////////

    // one packet word (cell) on the input FIFO and the memory bus
    localparam int DATA_W = 32;
    // shared packet memory word address
    localparam int ADDR_W = 16;
    // switch port number
    localparam int PORT_W = 4;
    localparam int BYTES_PER_WORD = 4;

    ////////////////////////////////////////
    // free list and address layout
    ////////////////////////////////////////

    // port-local buffer slots
    localparam int FP_DEPTH = 128;
    localparam int FP_IDX_W = 7;
    // largest packet in words, header included
    localparam int MAX_WORDS = 127;

    // addr = {port, 5'b0, index}
    localparam int ADDR_IDX_LSB = 0;
    localparam int ADDR_PAD_LSB = ADDR_IDX_LSB + FP_IDX_W;
    localparam int ADDR_PORT_LSB = ADDR_W - PORT_W;
    localparam int ADDR_PAD_W = ADDR_PORT_LSB - ADDR_PAD_LSB;

    // build a port-local buffer address from its index
    function automatic logic [ADDR_W-1:0] make_addr(input logic [PORT_W-1:0] port,
                                                    input logic [FP_IDX_W-1:0] idx);
        logic [ADDR_W-1:0] addr;
        addr = '0;
        addr[ADDR_PORT_LSB +: PORT_W] = port;
        addr[ADDR_PAD_LSB +: ADDR_PAD_W] = '0;
        addr[ADDR_IDX_LSB +: FP_IDX_W] = idx;
        return addr;
    endfunction

endpackage

// File: sgdma_fmt_pkg.sv
package sgdma_fmt_pkg;

    ////////////////////////////////////////
    // header fields
    ////////////////////////////////////////

    localparam int CNT_W = 7;
    localparam int LEN_W = 11;
    localparam int PRIO_W = 3;
    // bits above length are unused in the header
    localparam int HDR_RSVD_W = sgdma_buf_pkg::DATA_W - LEN_W - PRIO_W - sgdma_buf_pkg::PORT_W;

    // header view, msb first: rsvd | length | priority | destination
    typedef struct packed {
        logic [HDR_RSVD_W-1:0]           rsvd;
        logic [LEN_W-1:0]                len;
        logic [PRIO_W-1:0]               prio;
        logic [sgdma_buf_pkg::PORT_W-1:0] dest;
    } hdr_view_t;

    // one input word, header or payload
    typedef union packed {
        logic [sgdma_buf_pkg::DATA_W-1:0] raw;
        hdr_view_t                        hdr;
    } cell_word_u;

    ////////////////////////////////////////
    // dispatch descriptor
    ////////////////////////////////////////

    // msb first: first addr | word count | priority | destination
    localparam int DESC_DEST_LSB = 0;
    localparam int DESC_PRIO_LSB = DESC_DEST_LSB + sgdma_buf_pkg::PORT_W;
    localparam int DESC_CNT_LSB = DESC_PRIO_LSB + PRIO_W;
    localparam int DESC_ADDR_LSB = DESC_CNT_LSB + CNT_W;
    localparam int DESC_W = DESC_ADDR_LSB + sgdma_buf_pkg::ADDR_W;

    // words in a packet, header plus ceil(len / 4) payload words
    function automatic logic [CNT_W-1:0] word_count(input logic [LEN_W-1:0] len);
        logic [LEN_W:0] rnd;
        rnd = {1'b0, len} + (LEN_W + 1)'(sgdma_buf_pkg::BYTES_PER_WORD - 1);
        return CNT_W'(rnd / sgdma_buf_pkg::BYTES_PER_WORD) + CNT_W'(1);
    endfunction

    function automatic logic [DESC_W-1:0] make_desc(
        input logic [sgdma_buf_pkg::ADDR_W-1:0] addr,
        input logic [CNT_W-1:0]                 cnt,
        input logic [PRIO_W-1:0]                prio,
        input logic [sgdma_buf_pkg::PORT_W-1:0] dest
    );
        logic [DESC_W-1:0] desc;
        desc = '0;
        desc[DESC_ADDR_LSB +: sgdma_buf_pkg::ADDR_W] = addr;
        desc[DESC_CNT_LSB +: CNT_W] = cnt;
        desc[DESC_PRIO_LSB +: PRIO_W] = prio;
        desc[DESC_DEST_LSB +: sgdma_buf_pkg::PORT_W] = dest;
        return desc;
    endfunction

endpackage

// File: free_ptr_list.sv
`timescale 1ns/10ps

module free_ptr_list (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_locked,
    input  logic [sgdma_buf_pkg::PORT_W-1:0] i_port_id,
    input  logic                             i_fp_wr_en,
    input  logic [sgdma_buf_pkg::ADDR_W-1:0] i_fp_wr_dat,
    input  logic                             i_fp_pop,
    output logic [sgdma_buf_pkg::ADDR_W-1:0] o_fp_addr,
    output logic                             o_fp_empty
);
    import sgdma_buf_pkg::*;

    // address storage, one slot per buffer
    logic [ADDR_W-1:0] mem [FP_DEPTH];
    // extra msb tells full from empty
    logic [FP_IDX_W:0] wr_ptr;
    logic [FP_IDX_W:0] rd_ptr;
    // index of the next address to seed
    logic [FP_IDX_W:0] init_cnt;
    logic              init_done;
    logic              init_busy;
    logic              fp_full;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_dat;

    ////////////////////////////////////////
    // write port mux
    ////////////////////////////////////////

    // msb of init_cnt sets after the last of the 128 seeds
    assign init_done = init_cnt[FP_IDX_W];
    // seed one index per cycle once the clock is locked
    assign init_busy = i_locked && !init_done;

    // after the fill the memory manager owns the write port
    assign wr_en = init_busy || i_fp_wr_en;
    assign wr_dat = init_busy ? make_addr(i_port_id, init_cnt[FP_IDX_W-1:0]) : i_fp_wr_dat;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            init_cnt <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (init_busy) begin
                init_cnt <= init_cnt + 1'b1;
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_fp_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr[FP_IDX_W-1:0]] <= wr_dat;
        end
    end

    ////////////////////////////////////////
    // status and head entry
    ////////////////////////////////////////

    assign o_fp_empty = (wr_ptr == rd_ptr);
    assign fp_full = (wr_ptr[FP_IDX_W] != rd_ptr[FP_IDX_W])
                  && (wr_ptr[FP_IDX_W-1:0] == rd_ptr[FP_IDX_W-1:0]);
    // fall-through, head is visible before the pop
    assign o_fp_addr = mem[rd_ptr[FP_IDX_W-1:0]];

    // dma must check empty before taking an address
    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fp_pop |-> !o_fp_empty);

    // returned addresses only after the seed pass and never on overflow
    a_refill_ok: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fp_wr_en |-> init_done && !fp_full);

endmodule

// File: ingress_fsm.sv
`timescale 1ns/10ps

module ingress_fsm (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_locked,
    input  logic [sgdma_buf_pkg::DATA_W-1:0]  i_dat,
    input  logic                              i_empty,
    input  logic [sgdma_buf_pkg::ADDR_W-1:0]  i_fp_addr,
    input  logic                              i_fp_empty,
    input  logic                              i_mmu_wr_ready,
    input  logic                              i_q_full,
    output logic                              o_rd_en,
    output logic                              o_fp_pop,
    output logic                              o_mmu_wr_en,
    output logic [sgdma_buf_pkg::ADDR_W-1:0]  o_mmu_wr_addr,
    output logic [sgdma_buf_pkg::DATA_W-1:0]  o_mmu_wr_dat,
    output logic                              o_mmu_wr_done,
    output logic                              o_q_push,
    output logic [sgdma_fmt_pkg::DESC_W-1:0]  o_q_desc,
    output logic                              o_aply_req,
    output logic [sgdma_fmt_pkg::CNT_W-1:0]   o_aply_len
);
    import sgdma_buf_pkg::*;
    import sgdma_fmt_pkg::*;

    // idle waits for a header, body moves payload, drain waits for the last write
    typedef enum logic [1:0] {
        S_IDLE,
        S_BODY,
        S_DRAIN,
        S_DONE
    } state_t;

    state_t            state;
    // input word seen through the header view
    cell_word_u        hdr_w;
    logic [CNT_W-1:0]  hdr_cnt;
    // payload words still to pop
    logic [CNT_W-1:0]  rem_cnt;
    logic              src_ok;
    logic              reg_free;
    logic              accept;
    logic              start;
    logic              body_pop;
    logic              pop;
    // single write stage toward memory
    logic              wr_vld;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_dat;
    logic              aply_req_q;
    logic [CNT_W-1:0]  aply_len_q;

    ////////////////////////////////////////
    // header decode and pop rules
    ////////////////////////////////////////

    assign hdr_w = i_dat;
    assign hdr_cnt = word_count(hdr_w.hdr.len);

    // a word moves only with an address beside it
    assign src_ok = !i_empty && !i_fp_empty;
    assign accept = wr_vld && i_mmu_wr_ready;
    // write stage empty or draining this cycle
    assign reg_free = !wr_vld || i_mmu_wr_ready;

    // new packet needs room for its descriptor
    assign start = (state == S_IDLE) && i_locked && src_ok && !i_q_full;
    assign body_pop = (state == S_BODY) && src_ok && reg_free;
    assign pop = start || body_pop;

    assign o_rd_en = pop;
    assign o_fp_pop = pop;

    // descriptor leaves together with the header pop
    assign o_q_push = start;
    assign o_q_desc = make_desc(i_fp_addr, hdr_cnt, hdr_w.hdr.prio, hdr_w.hdr.dest);

    ////////////////////////////////////////
    // packet FSM
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= S_IDLE;
            wr_vld <= 1'b0;
            rem_cnt <= '0;
            aply_req_q <= 1'b0;
        end else begin
            // refill request trails the header by one cycle
            aply_req_q <= start;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        wr_vld <= 1'b1;
                        rem_cnt <= hdr_cnt - 1'b1;
                        // header-only packet goes straight to drain
                        state <= (hdr_cnt == CNT_W'(1)) ? S_DRAIN : S_BODY;
                    end
                end
                S_BODY: begin
                    if (body_pop) begin
                        wr_vld <= 1'b1;
                        rem_cnt <= rem_cnt - 1'b1;
                        if (rem_cnt == CNT_W'(1)) begin
                            state <= S_DRAIN;
                        end
                    end else if (accept) begin
                        wr_vld <= 1'b0;
                    end
                end
                S_DRAIN: begin
                    // last word still in the write stage
                    if (accept) begin
                        wr_vld <= 1'b0;
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // write stage payload, loaded only on a pop so it holds under a stall
    always_ff @(posedge i_clk) begin
        if (pop) begin
            wr_addr <= i_fp_addr;
            wr_dat <= i_dat;
        end
        if (start) begin
            aply_len_q <= hdr_cnt;
        end
    end

    assign o_mmu_wr_en = wr_vld;
    assign o_mmu_wr_addr = wr_addr;
    assign o_mmu_wr_dat = wr_dat;
    assign o_mmu_wr_done = (state == S_DONE);
    assign o_aply_req = aply_req_q;
    assign o_aply_len = aply_len_q;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // stalled write keeps its request, address and data
    a_wr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_mmu_wr_en && !i_mmu_wr_ready
        |=> o_mmu_wr_en && $stable(o_mmu_wr_addr) && $stable(o_mmu_wr_dat));

    // fifo pop and free-list pop move in lock step, never from an empty FIFO
    a_pop_pair: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_rd_en || o_fp_pop) |-> (o_rd_en && o_fp_pop && !i_empty));

    // 504 bytes is the largest packet that fits the word counter
    a_hdr_len: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        start |-> hdr_w.hdr.len <= LEN_W'((MAX_WORDS - 1) * BYTES_PER_WORD));

endmodule

// File: dispatch_queue.sv
`timescale 1ns/10ps

module dispatch_queue (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_push,
    input  logic [sgdma_fmt_pkg::DESC_W-1:0] i_desc,
    input  logic                             i_cb_full,
    output logic                             o_full,
    output logic                             o_cb_wr_en,
    output logic [sgdma_fmt_pkg::DESC_W-1:0] o_cb_din
);
    import sgdma_fmt_pkg::*;

    // two slots, one for the packet being written and one waiting on the crossbar
    logic [DESC_W-1:0] slot [2];
    logic              wr_sel;
    logic              rd_sel;
    logic [1:0]        count;
    logic              pop;

    // send whenever something is queued and the crossbar has room
    assign pop = (count != 2'd0) && !i_cb_full;
    assign o_full = (count == 2'd2);
    assign o_cb_wr_en = pop;
    assign o_cb_din = slot[rd_sel];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_sel <= 1'b0;
            rd_sel <= 1'b0;
            count <= 2'd0;
        end else begin
            if (i_push) begin
                wr_sel <= !wr_sel;
            end
            if (pop) begin
                rd_sel <= !rd_sel;
            end
            // push and pop together leave the count alone
            if (i_push && !pop) begin
                count <= count + 2'd1;
            end else if (!i_push && pop) begin
                count <= count - 2'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            slot[wr_sel] <= i_desc;
        end
    end

    // ingress must hold its header while both slots are taken
    a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> !o_full);

endmodule

// File: port_sgdma_top.sv
`timescale 1ns/10ps

module port_sgdma_top #(
    parameter logic [sgdma_buf_pkg::PORT_W-1:0] port_id = '0
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_locked,
    // input FIFO
    output logic                             o_rd_en,
    input  logic [sgdma_buf_pkg::DATA_W-1:0] i_dat,
    input  logic                             i_empty,
    // memory write channel
    output logic                             o_mmu_wr_en,
    output logic [sgdma_buf_pkg::ADDR_W-1:0] o_mmu_wr_addr,
    output logic [sgdma_buf_pkg::DATA_W-1:0] o_mmu_wr_dat,
    input  logic                             i_mmu_wr_ready,
    output logic                             o_mmu_wr_done,
    // crossbar
    output logic                             o_cb_wr_en,
    output logic [sgdma_fmt_pkg::DESC_W-1:0] o_cb_din,
    input  logic                             i_cb_full,
    // free-list refill
    input  logic                             i_fp_wr_en,
    input  logic [sgdma_buf_pkg::ADDR_W-1:0] i_fp_wr_dat,
    output logic                             o_aply_req,
    output logic [sgdma_fmt_pkg::CNT_W-1:0]  o_aply_len
);
    import sgdma_buf_pkg::*;
    import sgdma_fmt_pkg::*;

    logic [ADDR_W-1:0] fp_addr;
    logic              fp_empty;
    logic              fp_pop;
    logic              q_push;
    logic [DESC_W-1:0] q_desc;
    logic              q_full;

    ////////////////////////////////////////
    // free address list
    ////////////////////////////////////////

    free_ptr_list u_free_ptr_list (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_locked    (i_locked),
        .i_port_id   (port_id),
        .i_fp_wr_en  (i_fp_wr_en),
        .i_fp_wr_dat (i_fp_wr_dat),
        .i_fp_pop    (fp_pop),
        .o_fp_addr   (fp_addr),
        .o_fp_empty  (fp_empty)
    );

    ////////////////////////////////////////
    // packet mover
    ////////////////////////////////////////

    ingress_fsm u_ingress_fsm (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_locked       (i_locked),
        .i_dat          (i_dat),
        .i_empty        (i_empty),
        .i_fp_addr      (fp_addr),
        .i_fp_empty     (fp_empty),
        .i_mmu_wr_ready (i_mmu_wr_ready),
        .i_q_full       (q_full),
        .o_rd_en        (o_rd_en),
        .o_fp_pop       (fp_pop),
        .o_mmu_wr_en    (o_mmu_wr_en),
        .o_mmu_wr_addr  (o_mmu_wr_addr),
        .o_mmu_wr_dat   (o_mmu_wr_dat),
        .o_mmu_wr_done  (o_mmu_wr_done),
        .o_q_push       (q_push),
        .o_q_desc       (q_desc),
        .o_aply_req     (o_aply_req),
        .o_aply_len     (o_aply_len)
    );

    // descriptors wait here for crossbar room
    dispatch_queue u_dispatch_queue (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_push     (q_push),
        .i_desc     (q_desc),
        .i_cb_full  (i_cb_full),
        .o_full     (q_full),
        .o_cb_wr_en (o_cb_wr_en),
        .o_cb_din   (o_cb_din)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);
    // 20 ns period
    initial begin
        o_clk = 1'b0;
        forever begin
            #10 o_clk = ~o_clk;
        end
    end

    // reset low for the first 16 rising edges
    initial begin
        o_rst_n = 1'b0;
        repeat (16) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

// File: tb_port_sgdma.sv
`timescale 1ns/10ps

module tb_port_sgdma;
    import sgdma_buf_pkg::*;
    import sgdma_fmt_pkg::*;

    localparam logic [3:0] PORT_ID = 4'd5;
    // init, random back-pressure and refill tests
    localparam int NUM_PKTS = 53;
    localparam int NUM_WORDS = NUM_PKTS * MAX_WORDS;
    // 1.5 x worst-case words x 8 cycles plus slack
    localparam int WD_CYCLES = ((NUM_WORDS * 3) / 2) * 8 + 200;

    logic clk, rst_n, i_locked, i_empty, i_mmu_wr_ready, i_cb_full, i_fp_wr_en;
    logic [DATA_W-1:0] i_dat;
    logic [ADDR_W-1:0] i_fp_wr_dat;
    logic o_rd_en, o_mmu_wr_en, o_mmu_wr_done, o_cb_wr_en, o_aply_req;
    logic [ADDR_W-1:0] o_mmu_wr_addr;
    logic [DATA_W-1:0] o_mmu_wr_dat;
    logic [DESC_W-1:0] o_cb_din;
    logic [CNT_W-1:0] o_aply_len;

    // packet table and the input FIFO contents
    logic [DATA_W-1:0] words [NUM_WORDS];
    int pkt_len [NUM_PKTS], pkt_prio [NUM_PKTS], pkt_dest [NUM_PKTS];
    int pkt_first [NUM_PKTS], pkt_end [NUM_PKTS];
    // model free list plus addresses of popped and of written words
    logic [ADDR_W-1:0] free_q [$], addr_q [$], used_q [$];
    logic [DESC_W-1:0] desc_q [$];

    logic [31:0] gen_state = 32'd57823, bp_state = 32'd57823;
    string cur_test = "reset";
    int err_cnt = 0, pass_cnt = 0, fail_cnt = 0;
    int fifo_lim = 0, rd_ptr = 0, wr_idx = 0, pop_pkt = 0, wr_pkt = 0;
    int done_cnt = 0, desc_cnt = 0, pop_total = 0, lock_cyc = 0;
    logic calm = 1'b1, done_due = 1'b0, aply_due = 1'b0;
    int aply_cnt = 0;
    // addresses handed back to the free list so far
    int ret_total = 0;

    tb_clock_gen u_clock_gen (.o_clk(clk), .o_rst_n(rst_n));

    port_sgdma_top #(.port_id(PORT_ID)) dut (
        .i_clk(clk), .i_rst_n(rst_n), .i_locked(i_locked),
        .o_rd_en(o_rd_en), .i_dat(i_dat), .i_empty(i_empty),
        .o_mmu_wr_en(o_mmu_wr_en), .o_mmu_wr_addr(o_mmu_wr_addr),
        .o_mmu_wr_dat(o_mmu_wr_dat), .i_mmu_wr_ready(i_mmu_wr_ready),
        .o_mmu_wr_done(o_mmu_wr_done), .o_cb_wr_en(o_cb_wr_en), .o_cb_din(o_cb_din),
        .i_cb_full(i_cb_full), .i_fp_wr_en(i_fp_wr_en), .i_fp_wr_dat(i_fp_wr_dat),
        .o_aply_req(o_aply_req), .o_aply_len(o_aply_len)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // header plus one word per 4 payload bytes rounded up
    function automatic int words_in_packet(input int len);
        return 1 + (len + 3) / 4;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("error %s %s expected %h actual %h", cur_test, what, exp, act);
        err_cnt++;
    endtask

    task automatic report_problem(input string what);
        $display("%s: %s", cur_test, what);
        err_cnt++;
    endtask

    task automatic build_packets();
        cell_word_u hw;
        int n;
        int len;
        n = 0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            gen_state = xorshift(gen_state);
            // short fixed sizes first and full 504-byte packets last
            if (p < 3) len = (p == 0) ? 0 : (p == 1) ? 5 : 16;
            else if (p >= 43) len = 504;
            else len = int'(gen_state % 505);
            pkt_len[p] = len;
            pkt_prio[p] = int'(gen_state[13:11]);
            pkt_dest[p] = int'(gen_state[19:16]);
            pkt_first[p] = n;
            // rsvd bits stay random as the DMA ignores them
            hw.raw = xorshift(gen_state);
            hw.hdr.len = LEN_W'(len);
            hw.hdr.prio = PRIO_W'(pkt_prio[p]);
            hw.hdr.dest = PORT_W'(pkt_dest[p]);
            words[n] = hw.raw;
            n++;
            for (int w = 1; w < words_in_packet(len); w++) begin
                gen_state = xorshift(gen_state);
                words[n] = gen_state;
                n++;
            end
            pkt_end[p] = n;
        end
    endtask

    ////////////////////////////////////////
    // protocol checks
    ////////////////////////////////////////

    a_rd_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        o_rd_en |-> !i_empty) else report_problem("input FIFO popped while empty");

    a_cb_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        o_cb_wr_en |-> !i_cb_full) else report_problem("crossbar written while full");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !(o_rd_en || o_mmu_wr_en || o_mmu_wr_done || o_cb_wr_en || o_aply_req))
        else report_problem("strobe active during reset");

    ////////////////////////////////////////
    // models, drivers and value checks
    ////////////////////////////////////////

    always @(posedge clk) begin : model
        logic [31:0] r;
        logic hdr_pop;
        logic last_xfer;
        int idx;
        hdr_pop = 1'b0;
        last_xfer = 1'b0;
        bp_state = xorshift(bp_state);
        r = bp_state;
        if (rst_n) begin
            if (i_locked) lock_cyc++;
            // memory write channel checked on every cycle with en high
            if (o_mmu_wr_en) begin
                if (addr_q.size() == 0 || wr_idx >= fifo_lim) begin
                    report_problem("memory write with no word popped for it");
                end else begin
                    assert (o_mmu_wr_addr == addr_q[0])
                        else report_mismatch("write address", addr_q[0], o_mmu_wr_addr);
                    assert (o_mmu_wr_dat == words[wr_idx])
                        else report_mismatch("write data", words[wr_idx], o_mmu_wr_dat);
                    if (i_mmu_wr_ready) begin
                        used_q.push_back(addr_q.pop_front());
                        wr_idx++;
                        if (wr_idx == pkt_end[wr_pkt]) begin
                            last_xfer = 1'b1;
                            wr_pkt++;
                        end
                    end
                end
            end
            assert (o_mmu_wr_done == done_due)
                else report_mismatch("done pulse", 32'(done_due), 32'(o_mmu_wr_done));
            if (o_mmu_wr_done) done_cnt++;
            done_due = last_xfer;
            // refill request one cycle after the header pop
            assert (o_aply_req == aply_due)
                else report_mismatch("refill request", 32'(aply_due), 32'(o_aply_req));
            if (aply_due && o_aply_req) begin
                assert (o_aply_len == CNT_W'(aply_cnt))
                    else report_mismatch("refill length", 32'(aply_cnt), 32'(o_aply_len));
            end
            // input FIFO pop takes the model's head address
            if (o_rd_en && rd_ptr < fifo_lim) begin
                if (free_q.size() == 0) begin
                    report_problem("word popped with no free address left");
                end else begin
                    if (rd_ptr == pkt_first[pop_pkt]) begin
                        hdr_pop = 1'b1;
                        aply_cnt = words_in_packet(pkt_len[pop_pkt]);
                        desc_q.push_back({free_q[0], CNT_W'(aply_cnt),
                                          PRIO_W'(pkt_prio[pop_pkt]),
                                          PORT_W'(pkt_dest[pop_pkt])});
                    end
                    addr_q.push_back(free_q.pop_front());
                    pop_total++;
                    rd_ptr++;
                    if (rd_ptr == pkt_end[pop_pkt]) pop_pkt++;
                end
            end
            aply_due = hdr_pop;
            // crossbar descriptors in packet order
            if (o_cb_wr_en) begin
                if (desc_q.size() == 0) begin
                    report_problem("descriptor sent with no packet behind it");
                end else begin
                    assert (o_cb_din == desc_q[0])
                        else report_mismatch("descriptor", 32'(desc_q[0]), 32'(o_cb_din));
                    void'(desc_q.pop_front());
                    desc_cnt++;
                end
            end
            // next cycle's inputs
            i_mmu_wr_ready <= calm || (r[1:0] != 2'b00);
            i_cb_full <= !calm && (r[5:4] == 2'b00);
            i_empty <= (rd_ptr >= fifo_lim) || (!calm && r[9:8] == 2'b00);
            i_dat <= (rd_ptr < fifo_lim) ? words[rd_ptr] : '0;
            // return a random written address once the seed pass is over
            if (lock_cyc > FP_DEPTH + 2 && used_q.size() > 0 && r[12]) begin
                idx = int'(r[31:16]) % used_q.size();
                i_fp_wr_en <= 1'b1;
                i_fp_wr_dat <= used_q[idx];
                free_q.push_back(used_q[idx]);
                used_q.delete(idx);
                ret_total++;
            end else begin
                i_fp_wr_en <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic run_test(input string name, input int first, input int n,
                            input logic calm_mode);
        int err0;
        int ret0;
        @(negedge clk);
        err0 = err_cnt;
        ret0 = ret_total;
        cur_test = name;
        calm = calm_mode;
        fifo_lim = pkt_end[first + n - 1];
        while (done_cnt < first + n || desc_cnt < first + n) @(negedge clk);
        // free list order puts addresses returned in this test after seeds and older returns
        if (name == "refill") begin
            assert (pop_total > FP_DEPTH + ret0)
                else report_problem("no address returned during the test was used");
        end
        if (err_cnt == err0) begin
            pass_cnt++;
            $display("test %s ok, %0d packets", name, n);
        end else begin
            fail_cnt++;
            $display("test %s failed with %0d errors", name, err_cnt - err0);
        end
    endtask

    initial begin
        i_locked = 1'b0;
        i_dat = '0;
        i_empty = 1'b1;
        i_mmu_wr_ready = 1'b0;
        i_cb_full = 1'b0;
        i_fp_wr_en = 1'b0;
        i_fp_wr_dat = '0;
        // seed order of the free list is indices 0 to 127 on port 5
        for (int i = 0; i < FP_DEPTH; i++) free_q.push_back({PORT_ID, 5'b00000, 7'(i)});
        build_packets();
        @(posedge rst_n);
        @(posedge clk);
        i_locked <= 1'b1;
        run_test("init_addr", 0, 3, 1'b1);
        run_test("random_bp", 3, 40, 1'b0);
        run_test("refill", 43, 10, 1'b0);
        repeat (20) @(negedge clk);
        assert (desc_q.size() == 0 && addr_q.size() == 0)
            else report_problem("words or descriptors left over at the end");
        $display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles in test %s", WD_CYCLES, cur_test);
        $display("sim failed");
        $finish;
    end

endmodule

// File: port_sgdma.f
sgdma_buf_pkg.sv
sgdma_fmt_pkg.sv
free_ptr_list.sv
ingress_fsm.sv
dispatch_queue.sv
port_sgdma_top.sv
tb_clock_gen.sv
tb_port_sgdma.sv

// File: run_sim.sh
#!/bin/sh
# build the port DMA testbench with Verilator, run it, and grep the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_port_sgdma \
    -f port_sgdma.f -o sim_port_sgdma > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_port_sgdma > sim.log 2>&1 ; cat sim.log

grep -qx "sim passed" sim.log && exit 0 || exit 1
